// ==== hdl/panel_pkg.sv ====
`default_nettype none

package panel_pkg;

	// which test pattern is on screen
	typedef logic [1:0] pattern_t;

	// pattern codes, stepped in this order by the key
	localparam pattern_t PAT_BARS = 2'd0;
	localparam pattern_t PAT_GRADIENT = 2'd1;
	localparam pattern_t PAT_CHECKER = 2'd2;
	localparam pattern_t PAT_WHITE = 2'd3;

	// seven segment drive, gfedcba, a zero lights the segment
	typedef logic [6:0] seg_t;

	// debounce hold counter
	typedef logic [4:0] debounce_cnt_t;

	// cycles of stable level before a key edge counts
	// short for simulation, a board build wants a few ms worth
	localparam debounce_cnt_t DEBOUNCE_CYCLES = 5'd16;

	// key debounce fsm
	typedef enum logic [1:0] {
		released,
		press_wait,
		pressed,
		release_wait
	} debounce_state_t;

endpackage

`default_nettype wire

// ==== hdl/pattern_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module pattern_gen (
	input logic clk,
	input logic rst,
	input vga_pkg::h_count_t h_count,
	input vga_pkg::v_count_t v_count,
	input logic hsync,
	input logic vsync,
	input logic active,
	input panel_pkg::pattern_t pattern,
	output logic hsync_out,
	output logic vsync_out,
	output vga_pkg::color_t red,
	output vga_pkg::color_t green,
	output vga_pkg::color_t blue
);

	logic [2:0] bar;
	vga_pkg::color_t gradient;
	logic checker_on;
	vga_pkg::color_t red_next;
	vga_pkg::color_t green_next;
	vga_pkg::color_t blue_next;

	// per pixel pattern terms
	always_comb begin
		// bar 0..7 in the visible line, blanking values wrap but get masked
		bar = 3'(h_count / vga_pkg::BAR_WIDTH);
		// ramp from 0 to 159 across the line
		gradient = vga_pkg::color_t'(h_count >> 3);
		// squares flip when either coordinate crosses a 64 pixel boundary
		checker_on = h_count[vga_pkg::CHECK_SHIFT] ^ v_count[vga_pkg::CHECK_SHIFT];
	end

	// colour select
	always_comb begin
		red_next = '0;
		green_next = '0;
		blue_next = '0;
		case (pattern)
			panel_pkg::PAT_BARS: begin
				// white yellow cyan green magenta red blue black
				red_next = bar[1] ? '0 : '1;
				green_next = bar[2] ? '0 : '1;
				blue_next = bar[0] ? '0 : '1;
			end
			panel_pkg::PAT_GRADIENT: begin
				// red ramp only
				red_next = gradient;
			end
			panel_pkg::PAT_CHECKER: begin
				red_next = checker_on ? '1 : '0;
				green_next = checker_on ? '1 : '0;
				blue_next = checker_on ? '1 : '0;
			end
			panel_pkg::PAT_WHITE: begin
				red_next = '1;
				green_next = '1;
				blue_next = '1;
			end
		endcase
		// nothing drives the dac in blanking
		if (!active) begin
			red_next = '0;
			green_next = '0;
			blue_next = '0;
		end
	end

	// stage 2 registers, sync rides along with the colour
	always_ff @(posedge clk) begin
		if (rst) begin
			hsync_out <= 1'b0;
			vsync_out <= 1'b0;
			red <= '0;
			green <= '0;
			blue <= '0;
		end else begin
			hsync_out <= hsync;
			vsync_out <= vsync;
			red <= red_next;
			green <= green_next;
			blue <= blue_next;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/pattern_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module pattern_select (
	input logic clk,
	input logic rst,
	input logic key_n,
	output panel_pkg::pattern_t pattern
);

	panel_pkg::debounce_state_t state;
	panel_pkg::debounce_state_t state_next;
	panel_pkg::debounce_cnt_t cnt;
	panel_pkg::debounce_cnt_t cnt_next;
	logic hold_done;
	logic press_accept;

	// last sample of the hold window
	assign hold_done = (cnt == panel_pkg::DEBOUNCE_CYCLES - panel_pkg::debounce_cnt_t'(1));

	always_comb begin
		state_next = state;
		cnt_next = cnt + panel_pkg::debounce_cnt_t'(1);
		press_accept = 1'b0;
		case (state)
			panel_pkg::released: begin
				// first low sample starts the press window
				cnt_next = panel_pkg::debounce_cnt_t'(1);
				if (!key_n) begin
					state_next = panel_pkg::press_wait;
				end
			end
			panel_pkg::press_wait: begin
				if (key_n) begin
					// bounce, start over
					state_next = panel_pkg::released;
				end else if (hold_done) begin
					state_next = panel_pkg::pressed;
					press_accept = 1'b1;
				end
			end
			panel_pkg::pressed: begin
				cnt_next = panel_pkg::debounce_cnt_t'(1);
				if (key_n) begin
					state_next = panel_pkg::release_wait;
				end
			end
			panel_pkg::release_wait: begin
				// release only rearms the fsm
				if (!key_n) begin
					state_next = panel_pkg::pressed;
				end else if (hold_done) begin
					state_next = panel_pkg::released;
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= panel_pkg::released;
			cnt <= '0;
			pattern <= panel_pkg::PAT_BARS;
		end else begin
			state <= state_next;
			cnt <= cnt_next;
			// wraps 3 -> 0 by width
			if (press_accept) begin
				pattern <= pattern + panel_pkg::pattern_t'(1);
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/seg7_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module seg7_decoder (
	input panel_pkg::pattern_t pattern,
	output panel_pkg::seg_t hex0
);

	// digit table, gfedcba, low lights a segment
	always_comb begin
		case (pattern)
			// 0, all but g
			2'd0: hex0 = 7'h40;
			// 1, b and c
			2'd1: hex0 = 7'h79;
			// 2, a b d e g
			2'd2: hex0 = 7'h24;
			// 3, a b c d g
			2'd3: hex0 = 7'h30;
			default: hex0 = 7'h7f;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/vga_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_display (
	input logic clk,
	input logic rst,
	input logic key_n,
	output logic hsync,
	output logic vsync,
	output vga_pkg::color_t red,
	output vga_pkg::color_t green,
	output vga_pkg::color_t blue,
	output panel_pkg::seg_t hex0
);

	// stage 1 to stage 2
	vga_pkg::h_count_t h_count;
	vga_pkg::v_count_t v_count;
	logic hsync_raw;
	logic vsync_raw;
	logic active;

	// current pattern from the key
	panel_pkg::pattern_t pattern;

	// counters and sync
	vga_timing u_timing (
		.clk(clk),
		.rst(rst),
		.h_count(h_count),
		.v_count(v_count),
		.hsync(hsync_raw),
		.vsync(vsync_raw),
		.active(active)
	);

	// colour, sync delayed to match
	pattern_gen u_pattern (
		.clk(clk),
		.rst(rst),
		.h_count(h_count),
		.v_count(v_count),
		.hsync(hsync_raw),
		.vsync(vsync_raw),
		.active(active),
		.pattern(pattern),
		.hsync_out(hsync),
		.vsync_out(vsync),
		.red(red),
		.green(green),
		.blue(blue)
	);

	// push key steps the pattern
	pattern_select u_select (
		.clk(clk),
		.rst(rst),
		.key_n(key_n),
		.pattern(pattern)
	);

	// pattern number on the digit
	seg7_decoder u_seg (
		.pattern(pattern),
		.hex0(hex0)
	);

endmodule

`default_nettype wire

// ==== hdl/vga_pkg.sv ====
`default_nettype none

package vga_pkg;

	// horizontal position, covers the full 1688 clock line
	typedef logic [10:0] h_count_t;

	// vertical position, covers the full 1066 line frame
	typedef logic [10:0] v_count_t;

	// one 8 bit dac channel
	typedef logic [7:0] color_t;

	// 1280x1024 at 60 hz, 108 mhz pixel clock
	// horizontal segments in pixel clocks
	localparam h_count_t H_ACTIVE = 11'd1280;
	localparam h_count_t H_FRONT = 11'd48;
	localparam h_count_t H_SYNC = 11'd112;
	localparam h_count_t H_BACK = 11'd248;
	localparam h_count_t H_TOTAL = 11'd1688;

	// vertical segments in lines
	localparam v_count_t V_ACTIVE = 11'd1024;
	localparam v_count_t V_FRONT = 11'd1;
	localparam v_count_t V_SYNC = 11'd3;
	localparam v_count_t V_BACK = 11'd38;
	localparam v_count_t V_TOTAL = 11'd1066;

	// eight bars across the visible line
	localparam h_count_t BAR_WIDTH = 11'd160;

	// position bit that picks the checker square, 64 pixel squares
	localparam int CHECK_SHIFT = 6;

endpackage

`default_nettype wire

// ==== hdl/vga_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_timing (
	input logic clk,
	input logic rst,
	output vga_pkg::h_count_t h_count,
	output vga_pkg::v_count_t v_count,
	output logic hsync,
	output logic vsync,
	output logic active
);

	vga_pkg::h_count_t h_next;
	vga_pkg::v_count_t v_next;
	logic h_wrap;
	logic hsync_next;
	logic vsync_next;
	logic active_next;

	// next counter values
	always_comb begin
		h_wrap = (h_count == vga_pkg::H_TOTAL - vga_pkg::h_count_t'(1));
		if (h_wrap) begin
			h_next = '0;
		end else begin
			h_next = h_count + vga_pkg::h_count_t'(1);
		end
		// line counter only moves at end of line
		v_next = v_count;
		if (h_wrap) begin
			if (v_count == vga_pkg::V_TOTAL - vga_pkg::v_count_t'(1)) begin
				v_next = '0;
			end else begin
				v_next = v_count + vga_pkg::v_count_t'(1);
			end
		end
	end

	// flags decoded from the next counts so that the registered
	// flags line up with the registered counters
	always_comb begin
		hsync_next = (h_next >= vga_pkg::H_ACTIVE + vga_pkg::H_FRONT) &&
			(h_next < vga_pkg::H_ACTIVE + vga_pkg::H_FRONT + vga_pkg::H_SYNC);
		vsync_next = (v_next >= vga_pkg::V_ACTIVE + vga_pkg::V_FRONT) &&
			(v_next < vga_pkg::V_ACTIVE + vga_pkg::V_FRONT + vga_pkg::V_SYNC);
		// visible area only
		active_next = (h_next < vga_pkg::H_ACTIVE) && (v_next < vga_pkg::V_ACTIVE);
	end

	// stage 1 registers
	always_ff @(posedge clk) begin
		if (rst) begin
			h_count <= '0;
			v_count <= '0;
			hsync <= 1'b0;
			vsync <= 1'b0;
			// origin is the first visible pixel
			active <= 1'b1;
		end else begin
			h_count <= h_next;
			v_count <= v_next;
			hsync <= hsync_next;
			vsync <= vsync_next;
			active <= active_next;
		end
	end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with verilator, run it, pass only on the pass line
verilator --binary --timing --timescale 1ns/1ps --top-module vga_display_tb \
	-f vga_display.f &&
./obj_dir/Vvga_display_tb | tee /dev/stderr | grep -F '** PASS **' > /dev/null &&
echo "vga_display: simulation passed" ||
{ echo "vga_display: simulation failed"; exit 1; }

// ==== tests/vga_display_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_display_tb;

	// dut ports
	logic clk;
	logic rst;
	logic key_n;
	logic hsync;
	logic vsync;
	vga_pkg::color_t red;
	vga_pkg::color_t green;
	vga_pkg::color_t blue;
	panel_pkg::seg_t hex0;

	// levels put on the inputs at the next rising edge
	logic rst_level;
	logic key_level;

	// sync edges seen at the last falling edge sample
	logic hs_rise;
	logic hs_fall;
	logic vs_rise;
	logic vs_fall;

	// screen position rebuilt from the sync edges only
	int hcnt;
	int lcnt;
	logic h_lock;
	logic v_lock;
	int px;
	int py;

	panel_pkg::pattern_t cur_pattern;
	int errors;
	int checks;
	integer seed;
	int cycles = 0;
	// four frames, the tests need about three
	int cycle_limit = 4 * int'(vga_pkg::H_TOTAL) * int'(vga_pkg::V_TOTAL);

	vga_display dut (
		.clk(clk),
		.rst(rst),
		.key_n(key_n),
		.hsync(hsync),
		.vsync(vsync),
		.red(red),
		.green(green),
		.blue(blue),
		.hex0(hex0)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// run limit
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: tests still running after %0d cycles", cycles);
			$display("** FAIL **");
			$finish;
		end
	end

	task automatic check_color(input string what, input vga_pkg::color_t got,
		input vga_pkg::color_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_seg(input string what, input panel_pkg::seg_t got,
		input panel_pkg::seg_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is 7'h%h, expected 7'h%h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("Error at %0t: %s is %0d cycles, expected %0d", $time, what, got, exp);
		end
	endtask

	// digit shown for each pattern number
	function automatic panel_pkg::seg_t digit_segments(input panel_pkg::pattern_t pat);
		panel_pkg::seg_t seg;
		case (pat)
			panel_pkg::PAT_BARS: seg = 7'h40;
			panel_pkg::PAT_GRADIENT: seg = 7'h79;
			panel_pkg::PAT_CHECKER: seg = 7'h24;
			default: seg = 7'h30;
		endcase
		return seg;
	endfunction

	// channel value at x, y; ch 0 red, 1 green, 2 blue
	function automatic vga_pkg::color_t expected_channel(input panel_pkg::pattern_t pat,
		input int x, input int y, input int ch);
		int bar;
		logic on;
		bar = x / int'(vga_pkg::BAR_WIDTH);
		on = 1'b0;
		// blanking is black whatever the pattern
		if (x >= int'(vga_pkg::H_ACTIVE) || y >= int'(vga_pkg::V_ACTIVE)) begin
			return 8'h00;
		end
		case (pat)
			panel_pkg::PAT_BARS: begin
				if (ch == 0) begin
					on = (bar == 0) || (bar == 1) || (bar == 4) || (bar == 5);
				end else if (ch == 1) begin
					on = (bar <= 3);
				end else begin
					on = (bar % 2 == 0);
				end
			end
			panel_pkg::PAT_GRADIENT: begin
				// ramp on red only
				if (ch == 0) begin
					return vga_pkg::color_t'((x / 8) % 256);
				end
				return 8'h00;
			end
			panel_pkg::PAT_CHECKER: begin
				on = ((x >> vga_pkg::CHECK_SHIFT) % 2) != ((y >> vga_pkg::CHECK_SHIFT) % 2);
			end
			default: on = 1'b1;
		endcase
		return on ? 8'hff : 8'h00;
	endfunction

	// one clock: drive on the rising edge, sample on the falling edge
	task automatic step_pixel();
		logic prev_hs;
		logic prev_vs;
		prev_hs = hsync;
		prev_vs = vsync;
		@(posedge clk);
		rst <= rst_level;
		key_n <= key_level;
		@(negedge clk);
		hs_rise = !prev_hs && hsync;
		hs_fall = prev_hs && !hsync;
		vs_rise = !prev_vs && vsync;
		vs_fall = prev_vs && !vsync;
		// hsync falls at x = H_ACTIVE + H_FRONT + H_SYNC
		if (hs_fall) begin
			hcnt = 0;
			h_lock = 1'b1;
		end else begin
			hcnt = hcnt + 1;
		end
		// vsync falls at the start of a line, lines count at x = 0
		if (vs_fall) begin
			lcnt = 0;
			v_lock = h_lock;
		end else if (hcnt == int'(vga_pkg::H_BACK)) begin
			lcnt = lcnt + 1;
		end
		px = (hcnt + int'(vga_pkg::H_TOTAL) - int'(vga_pkg::H_BACK)) % int'(vga_pkg::H_TOTAL);
		py = (lcnt + int'(vga_pkg::V_TOTAL) - int'(vga_pkg::V_BACK)) % int'(vga_pkg::V_TOTAL);
	endtask

	// held press and release, both well past the debounce window
	task automatic press_key();
		int i;
		key_level = 1'b0;
		for (i = 0; i < int'(panel_pkg::DEBOUNCE_CYCLES) + 4; i++) begin
			step_pixel();
		end
		key_level = 1'b1;
		for (i = 0; i < int'(panel_pkg::DEBOUNCE_CYCLES) + 4; i++) begin
			step_pixel();
		end
		cur_pattern = cur_pattern + panel_pkg::pattern_t'(1);
		check_seg("hex0 after press", hex0, digit_segments(cur_pattern));
	endtask

	task automatic test_reset();
		int i;
		for (i = 0; i < 8; i++) begin
			// eighth reset edge, released after it
			if (i == 7) begin
				rst_level = 1'b0;
			end
			step_pixel();
			check_bit("hsync in reset", hsync, 1'b0);
			check_bit("vsync in reset", vsync, 1'b0);
			check_color("red in reset", red, 8'h00);
			check_color("green in reset", green, 8'h00);
			check_color("blue in reset", blue, 8'h00);
			check_seg("hex0 in reset", hex0, 7'h40);
		end
		// start of line 0, no sync yet
		for (i = 0; i < 4; i++) begin
			step_pixel();
			check_bit("hsync after reset", hsync, 1'b0);
			check_bit("vsync after reset", vsync, 1'b0);
			check_seg("hex0 after reset", hex0, 7'h40);
		end
	endtask

	task automatic test_debounce();
		int pulse;
		int len;
		int i;
		for (pulse = 0; pulse < 12; pulse++) begin
			// bounce shorter than the hold time
			len = 1 + int'($unsigned($random(seed)) % (int'(panel_pkg::DEBOUNCE_CYCLES) - 1));
			key_level = 1'b0;
			for (i = 0; i < len; i++) begin
				step_pixel();
				check_seg("hex0 during bounce", hex0, 7'h40);
			end
			len = 1 + int'($unsigned($random(seed)) % (int'(panel_pkg::DEBOUNCE_CYCLES) - 1));
			key_level = 1'b1;
			for (i = 0; i < len; i++) begin
				step_pixel();
				check_seg("hex0 during bounce", hex0, 7'h40);
			end
		end
		for (i = 0; i < int'(panel_pkg::DEBOUNCE_CYCLES) + 4; i++) begin
			step_pixel();
			check_seg("hex0 after bounce", hex0, 7'h40);
		end
		// 1, 2, 3, then back to 0
		repeat (4) press_key();
	endtask

	task automatic test_horizontal();
		int period;
		int high;
		do step_pixel(); while (!hs_rise);
		period = 0;
		high = 0;
		do begin
			if (hsync) begin
				high++;
			end
			step_pixel();
			period++;
		end while (!hs_rise);
		check_count("hsync period", period, int'(vga_pkg::H_TOTAL));
		check_count("hsync width", high, int'(vga_pkg::H_SYNC));
	endtask

	// every pixel of n whole lines from line y
	task automatic check_lines(input int y, input int n);
		int i;
		while (!(v_lock && py == y && px == 0)) begin
			step_pixel();
		end
		for (i = 0; i < n * int'(vga_pkg::H_TOTAL); i++) begin
			check_color($sformatf("red at %0d,%0d", px, py), red,
				expected_channel(cur_pattern, px, py, 0));
			check_color($sformatf("green at %0d,%0d", px, py), green,
				expected_channel(cur_pattern, px, py, 1));
			check_color($sformatf("blue at %0d,%0d", px, py), blue,
				expected_channel(cur_pattern, px, py, 2));
			step_pixel();
		end
	endtask

	// all four patterns inside one frame, the change lands mid frame
	task automatic test_patterns();
		check_lines(0, 2);
		press_key();
		check_lines(100, 2);
		press_key();
		// both phases of the squares in y
		check_lines(320, 1);
		check_lines(384, 1);
		press_key();
		check_lines(1021, 3);
	endtask

	// one frame of white, rise to rise
	task automatic test_vertical();
		int period;
		int high;
		int lit;
		logic line_lit;
		period = 0;
		high = 0;
		lit = 0;
		line_lit = 1'b0;
		while (!vs_rise) begin
			step_pixel();
		end
		do begin
			if (vsync) begin
				high++;
			end
			if (red != 8'h00 || green != 8'h00 || blue != 8'h00) begin
				line_lit = 1'b1;
			end
			// hsync falls in the blanking after each line's pixels
			if (hs_fall) begin
				if (line_lit) begin
					lit++;
				end
				line_lit = 1'b0;
			end
			step_pixel();
			period++;
		end while (!vs_rise);
		check_count("vsync period", period, int'(vga_pkg::H_TOTAL) * int'(vga_pkg::V_TOTAL));
		check_count("vsync width", high, int'(vga_pkg::V_SYNC) * int'(vga_pkg::H_TOTAL));
		check_count("lit lines", lit, int'(vga_pkg::V_ACTIVE));
	endtask

	initial begin
		rst <= 1'b1;
		key_n <= 1'b1;
		rst_level = 1'b1;
		key_level = 1'b1;
		hcnt = 0;
		lcnt = 0;
		h_lock = 1'b0;
		v_lock = 1'b0;
		px = 0;
		py = 0;
		cur_pattern = panel_pkg::PAT_BARS;
		errors = 0;
		checks = 0;
		seed = 32'h93ed_efc2;
		test_reset();
		test_debounce();
		test_horizontal();
		test_patterns();
		test_vertical();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vga_display.f ====
hdl/vga_pkg.sv
hdl/panel_pkg.sv
hdl/vga_timing.sv
hdl/pattern_gen.sv
hdl/pattern_select.sv
hdl/seg7_decoder.sv
hdl/vga_display.sv
tests/vga_display_tb.sv
